//--- include/rv32_opcodes.svh
// casez match patterns for the RV32IM instructions the decode stage recognises, used by the decoder
`ifndef RV32_OPCODES_SVH
`define RV32_OPCODES_SVH

// upper immediate and jumps
`define RV32_LUI    32'b????????????????????_?????_0110111
`define RV32_AUIPC  32'b????????????????????_?????_0010111
`define RV32_JAL    32'b????????????????????_?????_1101111
`define RV32_JALR   32'b???????_?????_?????_000_?????_1100111

// conditional branches
`define RV32_BEQ    32'b???????_?????_?????_000_?????_1100011
`define RV32_BNE    32'b???????_?????_?????_001_?????_1100011
`define RV32_BLT    32'b???????_?????_?????_100_?????_1100011
`define RV32_BGE    32'b???????_?????_?????_101_?????_1100011
`define RV32_BLTU   32'b???????_?????_?????_110_?????_1100011
`define RV32_BGEU   32'b???????_?????_?????_111_?????_1100011

// loads and stores
`define RV32_LB     32'b???????_?????_?????_000_?????_0000011
`define RV32_LH     32'b???????_?????_?????_001_?????_0000011
`define RV32_LW     32'b???????_?????_?????_010_?????_0000011
`define RV32_LBU    32'b???????_?????_?????_100_?????_0000011
`define RV32_LHU    32'b???????_?????_?????_101_?????_0000011
`define RV32_SB     32'b???????_?????_?????_000_?????_0100011
`define RV32_SH     32'b???????_?????_?????_001_?????_0100011
`define RV32_SW     32'b???????_?????_?????_010_?????_0100011

// register-immediate ALU ops
`define RV32_ADDI   32'b???????_?????_?????_000_?????_0010011
`define RV32_SLTI   32'b???????_?????_?????_010_?????_0010011
`define RV32_SLTIU  32'b???????_?????_?????_011_?????_0010011
`define RV32_XORI   32'b???????_?????_?????_100_?????_0010011
`define RV32_ORI    32'b???????_?????_?????_110_?????_0010011
`define RV32_ANDI   32'b???????_?????_?????_111_?????_0010011
`define RV32_SLLI   32'b0000000_?????_?????_001_?????_0010011
`define RV32_SRLI   32'b0000000_?????_?????_101_?????_0010011
`define RV32_SRAI   32'b0100000_?????_?????_101_?????_0010011

// register-register ALU ops
`define RV32_ADD    32'b0000000_?????_?????_000_?????_0110011
`define RV32_SUB    32'b0100000_?????_?????_000_?????_0110011
`define RV32_SLL    32'b0000000_?????_?????_001_?????_0110011
`define RV32_SLT    32'b0000000_?????_?????_010_?????_0110011
`define RV32_SLTU   32'b0000000_?????_?????_011_?????_0110011
`define RV32_XOR    32'b0000000_?????_?????_100_?????_0110011
`define RV32_SRL    32'b0000000_?????_?????_101_?????_0110011
`define RV32_SRA    32'b0100000_?????_?????_101_?????_0110011
`define RV32_OR     32'b0000000_?????_?????_110_?????_0110011
`define RV32_AND    32'b0000000_?????_?????_111_?????_0110011

// M extension multiplies, no divide support
`define RV32_MUL    32'b0000001_?????_?????_000_?????_0110011
`define RV32_MULH   32'b0000001_?????_?????_001_?????_0110011
`define RV32_MULHSU 32'b0000001_?????_?????_010_?????_0110011
`define RV32_MULHU  32'b0000001_?????_?????_011_?????_0110011

// system
`define RV32_CSRRW  32'b???????_?????_?????_001_?????_1110011
`define RV32_CSRRS  32'b???????_?????_?????_010_?????_1110011
`define RV32_CSRRC  32'b???????_?????_?????_011_?????_1110011
`define RV32_WFI    32'b0001000_00101_00000_000_00000_1110011

`endif

//--- rtl/decode_pkg.sv
// types and constants shared by the decode stage, imported by each module that needs them
package decode_pkg;

    localparam int xlen     = 32;
    localparam int num_regs = 32;

    typedef logic [$clog2(num_regs)-1:0] reg_idx_t;
    typedef logic [xlen-1:0]             word_t;

    typedef enum logic [1:0] {
        opa_is_rs1  = 2'h0,
        opa_is_pc   = 2'h1,
        opa_is_zero = 2'h2
    } alu_opa_select_e;

    typedef enum logic [2:0] {
        opb_is_rs2   = 3'h0,
        opb_is_i_imm = 3'h1,
        opb_is_s_imm = 3'h2,
        opb_is_b_imm = 3'h3,
        opb_is_u_imm = 3'h4,
        opb_is_j_imm = 3'h5
    } alu_opb_select_e;

    typedef enum logic [3:0] {
        alu_add    = 4'h0,
        alu_sub    = 4'h1,
        alu_slt    = 4'h2,
        alu_sltu   = 4'h3,
        alu_and    = 4'h4,
        alu_or     = 4'h5,
        alu_xor    = 4'h6,
        alu_sll    = 4'h7,
        alu_srl    = 4'h8,
        alu_sra    = 4'h9,
        alu_mul    = 4'ha,
        alu_mulh   = 4'hb,
        alu_mulhsu = 4'hc,
        alu_mulhu  = 4'hd
    } alu_func_e;

    // the six RISC-V encoding formats over the same word
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            reg_idx_t   rs2;
            reg_idx_t   rs1;
            logic [2:0] funct3;
            reg_idx_t   rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm11_0;
            reg_idx_t    rs1;
            logic [2:0]  funct3;
            reg_idx_t    rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm11_5;
            reg_idx_t   rs2;
            reg_idx_t   rs1;
            logic [2:0] funct3;
            logic [4:0] imm4_0;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            reg_idx_t   rs2;
            reg_idx_t   rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm31_12;
            reg_idx_t    rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            reg_idx_t   rd;
            logic [6:0] opcode;
        } j;
    } inst_t;

    typedef struct packed {
        alu_opa_select_e opa_select;
        alu_opb_select_e opb_select;
        alu_func_e       alu_func;
        logic            has_dest;
        logic            rd_mem;
        logic            wr_mem;
        logic            cond_branch;
        logic            uncond_branch;
        logic            csr_op;
        logic            halt;
        logic            illegal;
    } id_ctrl_t;

    // rs1 + rs2 with add and nothing else, i.e. a bubble
    localparam id_ctrl_t nop_ctrl = '{
        opa_select: opa_is_rs1,
        opb_select: opb_is_rs2,
        alu_func:   alu_add,
        default:    1'b0
    };

    typedef struct packed {
        logic     en;
        reg_idx_t idx;
        word_t    data;
    } wb_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        inst_t    inst;
        id_ctrl_t ctrl;
        word_t    rs1_value;
        word_t    rs2_value;
        word_t    imm;
        reg_idx_t dest_reg;   // rd, or 0 when nothing is written back
    } id_ex_packet_t;

endpackage

//--- rtl/decoder.sv
// combinational RV32IM decoder, turns one instruction word into the datapath control struct
`timescale 1ns/1ps

`include "rv32_opcodes.svh"

module decoder import decode_pkg::*; (
    input  inst_t    inst,
    input  logic     valid,   // low forces a NOP
    output id_ctrl_t ctrl
);

    always_comb begin
        ctrl = nop_ctrl;

        if (valid) begin
            casez (inst)
                `RV32_LUI: begin
                    ctrl.has_dest   = 1'b1;
                    ctrl.opa_select = opa_is_zero;   // 0 + imm
                    ctrl.opb_select = opb_is_u_imm;
                end
                `RV32_AUIPC: begin
                    ctrl.has_dest   = 1'b1;
                    ctrl.opa_select = opa_is_pc;
                    ctrl.opb_select = opb_is_u_imm;
                end
                `RV32_JAL: begin
                    ctrl.has_dest      = 1'b1;
                    ctrl.opa_select    = opa_is_pc;
                    ctrl.opb_select    = opb_is_j_imm;
                    ctrl.uncond_branch = 1'b1;
                end
                `RV32_JALR: begin
                    ctrl.has_dest      = 1'b1;
                    ctrl.opb_select    = opb_is_i_imm;   // target is rs1 + imm
                    ctrl.uncond_branch = 1'b1;
                end
                `RV32_BEQ, `RV32_BNE, `RV32_BLT,
                `RV32_BGE, `RV32_BLTU, `RV32_BGEU: begin
                    // ALU computes the target, compare happens in execute
                    ctrl.opa_select  = opa_is_pc;
                    ctrl.opb_select  = opb_is_b_imm;
                    ctrl.cond_branch = 1'b1;
                end
                `RV32_LB, `RV32_LH, `RV32_LW,
                `RV32_LBU, `RV32_LHU: begin
                    ctrl.has_dest   = 1'b1;
                    ctrl.opb_select = opb_is_i_imm;
                    ctrl.rd_mem     = 1'b1;
                end
                `RV32_SB, `RV32_SH, `RV32_SW: begin
                    ctrl.opb_select = opb_is_s_imm;
                    ctrl.wr_mem     = 1'b1;
                end
                `RV32_ADDI: begin
                    ctrl.has_dest   = 1'b1;
                    ctrl.opb_select = opb_is_i_imm;
                end
                `RV32_SLTI: begin
                    ctrl.has_dest   = 1'b1;
                    ctrl.opb_select = opb_is_i_imm;
                    ctrl.alu_func   = alu_slt;
                end
                `RV32_SLTIU: begin
                    ctrl.has_dest   = 1'b1;
                    ctrl.opb_select = opb_is_i_imm;
                    ctrl.alu_func   = alu_sltu;
                end
                `RV32_ANDI: begin
                    ctrl.has_dest   = 1'b1;
                    ctrl.opb_select = opb_is_i_imm;
                    ctrl.alu_func   = alu_and;
                end
                `RV32_ORI: begin
                    ctrl.has_dest   = 1'b1;
                    ctrl.opb_select = opb_is_i_imm;
                    ctrl.alu_func   = alu_or;
                end
                `RV32_XORI: begin
                    ctrl.has_dest   = 1'b1;
                    ctrl.opb_select = opb_is_i_imm;
                    ctrl.alu_func   = alu_xor;
                end
                // shift amount sits in the low 5 bits of the I immediate
                `RV32_SLLI: begin
                    ctrl.has_dest   = 1'b1;
                    ctrl.opb_select = opb_is_i_imm;
                    ctrl.alu_func   = alu_sll;
                end
                `RV32_SRLI: begin
                    ctrl.has_dest   = 1'b1;
                    ctrl.opb_select = opb_is_i_imm;
                    ctrl.alu_func   = alu_srl;
                end
                `RV32_SRAI: begin
                    ctrl.has_dest   = 1'b1;
                    ctrl.opb_select = opb_is_i_imm;
                    ctrl.alu_func   = alu_sra;
                end
                `RV32_ADD: begin
                    ctrl.has_dest = 1'b1;
                end
                `RV32_SUB: begin
                    ctrl.has_dest = 1'b1;
                    ctrl.alu_func = alu_sub;
                end
                `RV32_SLT: begin
                    ctrl.has_dest = 1'b1;
                    ctrl.alu_func = alu_slt;
                end
                `RV32_SLTU: begin
                    ctrl.has_dest = 1'b1;
                    ctrl.alu_func = alu_sltu;
                end
                `RV32_AND: begin
                    ctrl.has_dest = 1'b1;
                    ctrl.alu_func = alu_and;
                end
                `RV32_OR: begin
                    ctrl.has_dest = 1'b1;
                    ctrl.alu_func = alu_or;
                end
                `RV32_XOR: begin
                    ctrl.has_dest = 1'b1;
                    ctrl.alu_func = alu_xor;
                end
                `RV32_SLL: begin
                    ctrl.has_dest = 1'b1;
                    ctrl.alu_func = alu_sll;
                end
                `RV32_SRL: begin
                    ctrl.has_dest = 1'b1;
                    ctrl.alu_func = alu_srl;
                end
                `RV32_SRA: begin
                    ctrl.has_dest = 1'b1;
                    ctrl.alu_func = alu_sra;
                end
                `RV32_MUL: begin
                    ctrl.has_dest = 1'b1;
                    ctrl.alu_func = alu_mul;
                end
                `RV32_MULH: begin
                    ctrl.has_dest = 1'b1;
                    ctrl.alu_func = alu_mulh;
                end
                `RV32_MULHSU: begin
                    ctrl.has_dest = 1'b1;
                    ctrl.alu_func = alu_mulhsu;
                end
                `RV32_MULHU: begin
                    ctrl.has_dest = 1'b1;
                    ctrl.alu_func = alu_mulhu;
                end
                `RV32_CSRRW, `RV32_CSRRS, `RV32_CSRRC: begin
                    ctrl.csr_op = 1'b1;   // no CSR file here, flag only
                end
                `RV32_WFI: begin
                    ctrl.halt = 1'b1;
                end
                default: begin
                    ctrl.illegal = 1'b1;
                end
            endcase
        end
    end

endmodule

//--- rtl/imm_gen.sv
// sign-extended operand B immediate, picked by the decoded operand B source
`timescale 1ns/1ps

module imm_gen import decode_pkg::*; (
    input  inst_t           inst,
    input  alu_opb_select_e opb_select,
    output word_t           imm
);

    always_comb begin
        case (opb_select)
            opb_is_i_imm: begin
                imm = {{20{inst.i.imm11_0[11]}}, inst.i.imm11_0};
            end
            opb_is_s_imm: begin
                imm = {{20{inst.s.imm11_5[6]}}, inst.s.imm11_5, inst.s.imm4_0};
            end
            opb_is_b_imm: begin
                // bit 0 is always zero for branch offsets
                imm = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                       inst.b.imm10_5, inst.b.imm4_1, 1'b0};
            end
            opb_is_u_imm: begin
                imm = {inst.u.imm31_12, 12'h000};
            end
            opb_is_j_imm: begin
                imm = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
                       inst.j.imm11, inst.j.imm10_1, 1'b0};
            end
            default: begin
                imm = '0;   // register operand, no immediate
            end
        endcase
    end

endmodule

//--- rtl/regfile.sv
// architectural register file with two reads, one write-back port and same-cycle forwarding
`timescale 1ns/1ps

module regfile import decode_pkg::*; (
    input  logic     clock,
    input  logic     arst_n,
    input  reg_idx_t rd1_idx,
    input  reg_idx_t rd2_idx,
    output word_t    rd1_data,
    output word_t    rd2_data,
    input  wb_t      wb
);

    word_t regs [1:num_regs-1];   // x0 has no storage

    logic wr_live;   // a real write is happening this cycle

    assign wr_live = wb.en && (wb.idx != '0);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 1; r < num_regs; r++) begin
                regs[r] <= '0;
            end
        end else if (wr_live) begin
            regs[wb.idx] <= wb.data;
        end
    end

    // x0 reads zero, a write to the same index wins over storage
    always_comb begin
        rd1_data = '0;
        rd2_data = '0;
        if (rd1_idx != '0) begin
            rd1_data = (wr_live && wb.idx == rd1_idx) ? wb.data : regs[rd1_idx];
        end
        if (rd2_idx != '0) begin
            rd2_data = (wr_live && wb.idx == rd2_idx) ? wb.data : regs[rd2_idx];
        end
    end

endmodule

//--- rtl/stage_id.sv
// pipeline decode stage top, decodes and reads operands and registers the ID/EX packet
`timescale 1ns/1ps

module stage_id import decode_pkg::*; (
    input  logic          clock,
    input  logic          arst_n,
    input  logic          if_valid,
    input  word_t         if_pc,
    input  inst_t         if_inst,
    input  logic          stall,    // hold ID/EX
    input  logic          squash,   // next packet becomes a bubble
    input  wb_t           wb,
    output id_ex_packet_t id_ex
);

    id_ctrl_t      ctrl;
    word_t         imm;
    word_t         rs1_value;
    word_t         rs2_value;
    id_ex_packet_t next_packet;

    decoder u_decoder (
        .inst  (if_inst),
        .valid (if_valid),
        .ctrl  (ctrl)
    );

    imm_gen u_imm_gen (
        .inst       (if_inst),
        .opb_select (ctrl.opb_select),
        .imm        (imm)
    );

    regfile u_regfile (
        .clock    (clock),
        .arst_n   (arst_n),
        .rd1_idx  (if_inst.r.rs1),
        .rd2_idx  (if_inst.r.rs2),
        .rd1_data (rs1_value),
        .rd2_data (rs2_value),
        .wb       (wb)
    );

    always_comb begin
        next_packet.valid     = if_valid;
        next_packet.pc        = if_pc;
        next_packet.inst      = if_inst;
        next_packet.ctrl      = ctrl;
        next_packet.rs1_value = rs1_value;
        next_packet.rs2_value = rs2_value;
        next_packet.imm       = imm;
        next_packet.dest_reg  = ctrl.has_dest ? if_inst.r.rd : '0;   // stores and branches give 0
    end

    // ID/EX register, stall has priority over squash
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            id_ex <= '0;
        end else if (!stall) begin
            if (squash) begin
                id_ex <= '0;   // all-zero packet is invalid with NOP controls
            end else begin
                id_ex <= next_packet;
            end
        end
    end

endmodule

//--- sim.f
+incdir+include
rtl/decode_pkg.sv
rtl/decoder.sv
rtl/imm_gen.sv
rtl/regfile.sv
rtl/stage_id.sv
test/stage_id_properties.sv
test/stage_id_tb.sv

//--- test/stage_id_properties.sv
// concurrent checks on the ID/EX register, bound into every stage_id instance
`timescale 1ns/1ps

module stage_id_properties import decode_pkg::*; (
    input logic          clock,
    input logic          arst_n,
    input logic          stall,
    input id_ex_packet_t id_ex
);

    int fail_count = 0;   // read by the testbench when the run ends

    // first edge out of reset still shows the cleared packet
    valid_low_after_reset: assert property (@(posedge clock) $rose(arst_n) |-> !id_ex.valid)
        else begin
            $error("id_ex.valid is high in the first cycle after reset");
            fail_count++;
        end

    stall_holds_packet: assert property (
        @(posedge clock) disable iff (!arst_n) stall |=> $stable(id_ex)
    ) else begin
        $error("id_ex changed while stall was high");
        fail_count++;
    end

    // a word is either WFI or undefined, never both
    no_halt_and_illegal: assert property (
        @(posedge clock) disable iff (!arst_n) !(id_ex.ctrl.halt && id_ex.ctrl.illegal)
    ) else begin
        $error("id_ex carries halt and illegal together");
        fail_count++;
    end

endmodule

bind stage_id stage_id_properties u_props (
    .clock  (clock),
    .arst_n (arst_n),
    .stall  (stall),
    .id_ex  (id_ex)
);

//--- test/stage_id_tb.sv
// testbench for the decode stage, replays the vector file cycle by cycle and checks the ID/EX packet
`timescale 1ns/1ps

module stage_id_tb import decode_pkg::*; ();

    typedef struct packed {
        logic     if_valid;
        word_t    pc;
        inst_t    inst;
        logic     stall;
        logic     squash;
        wb_t      wb;
        logic     exp_valid;
        id_ctrl_t exp_ctrl;
        word_t    exp_rs1;
        word_t    exp_rs2;
        word_t    exp_imm;
        reg_idx_t exp_dest;
    } vector_t;

    localparam int max_vectors = 64;

    logic          clock;
    logic          arst_n;
    logic          if_valid;
    word_t         if_pc;
    inst_t         if_inst;
    logic          stall;
    logic          squash;
    wb_t           wb;
    id_ex_packet_t id_ex;

    vector_t vectors [0:max_vectors-1];
    int      num_vectors = 0;
    int      cycles = 0;

    stage_id UUT (
        .clock    (clock),
        .arst_n   (arst_n),
        .if_valid (if_valid),
        .if_pc    (if_pc),
        .if_inst  (if_inst),
        .stall    (stall),
        .squash   (squash),
        .wb       (wb),
        .id_ex    (id_ex)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    task automatic stop_on_error(string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1, "%s", what);
    endtask

    task automatic load_vectors();
        int         fd;
        int         code;
        string      line;
        int         v, st, sq, we, wi, ev;
        int         opa, opb, func, dest;
        word_t      pc, inst, wdata, rs1, rs2, imm;
        logic [7:0] flags;   // has_dest down to illegal
        vector_t    vec;
        fd = $fopen("test/stage_id_testdata.txt", "r");
        if (fd == 0) begin
            stop_on_error("cannot open the vector file test/stage_id_testdata.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 8 || line.substr(0, 1) == "//") begin
                continue;   // comment or blank line
            end
            code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %b %h %h %h %h",
                           v, pc, inst, st, sq, we, wi, wdata,
                           ev, opa, opb, func, flags, rs1, rs2, imm, dest);
            if (code != 17 || num_vectors == max_vectors) begin
                stop_on_error("the vector file holds a malformed line or too many lines");
            end
            vec.if_valid = v[0];
            vec.pc = pc;
            vec.inst = inst;
            vec.stall = st[0];
            vec.squash = sq[0];
            vec.wb = '{en: we[0], idx: wi[4:0], data: wdata};
            vec.exp_valid = ev[0];
            vec.exp_ctrl.opa_select = alu_opa_select_e'(opa[1:0]);
            vec.exp_ctrl.opb_select = alu_opb_select_e'(opb[2:0]);
            vec.exp_ctrl.alu_func = alu_func_e'(func[3:0]);
            vec.exp_ctrl.has_dest = flags[7];
            vec.exp_ctrl.rd_mem = flags[6];
            vec.exp_ctrl.wr_mem = flags[5];
            vec.exp_ctrl.cond_branch = flags[4];
            vec.exp_ctrl.uncond_branch = flags[3];
            vec.exp_ctrl.csr_op = flags[2];
            vec.exp_ctrl.halt = flags[1];
            vec.exp_ctrl.illegal = flags[0];
            vec.exp_rs1 = rs1;
            vec.exp_rs2 = rs2;
            vec.exp_imm = imm;
            vec.exp_dest = dest[4:0];
            vectors[num_vectors] = vec;
            num_vectors++;
        end
        $fclose(fd);
        if (num_vectors == 0) begin
            stop_on_error("the vector file holds no vectors");
        end
    endtask

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
        $display("FAIL at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        $display("Test FAILED");
        $fatal(1, "mismatch on %s", name);
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            report_mismatch(name, {31'd0, got}, {31'd0, exp});
        end
    endtask

    task automatic check_ctrl(id_ctrl_t got, id_ctrl_t exp);
        if (got !== exp) begin
            report_mismatch("id_ex.ctrl", {15'd0, got}, {15'd0, exp});
        end
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            report_mismatch(name, got, exp);
        end
    endtask

    task automatic check_inst(inst_t got, inst_t exp);
        if (got !== exp) begin
            report_mismatch("id_ex.inst", got, exp);
        end
    endtask

    task automatic check_idx(string name, reg_idx_t got, reg_idx_t exp);
        if (got !== exp) begin
            report_mismatch(name, {27'd0, got}, {27'd0, exp});
        end
    endtask

    task automatic apply_vector(vector_t vec);
        if_valid <= vec.if_valid;
        if_pc    <= vec.pc;
        if_inst  <= vec.inst;
        stall    <= vec.stall;
        squash   <= vec.squash;
        wb       <= vec.wb;
    endtask

    task automatic check_packet(vector_t vec, word_t exp_pc, inst_t exp_inst);
        check_bit("id_ex.valid", id_ex.valid, vec.exp_valid);
        check_ctrl(id_ex.ctrl, vec.exp_ctrl);
        check_word("id_ex.rs1_value", id_ex.rs1_value, vec.exp_rs1);
        check_word("id_ex.rs2_value", id_ex.rs2_value, vec.exp_rs2);
        check_word("id_ex.imm", id_ex.imm, vec.exp_imm);
        check_idx("id_ex.dest_reg", id_ex.dest_reg, vec.exp_dest);
        if (vec.exp_valid) begin
            check_word("id_ex.pc", id_ex.pc, exp_pc);   // a live packet carries its own pc
            check_inst(id_ex.inst, exp_inst);
        end
    endtask

    // run limit scales with the vector count, reset included in the margin
    always @(posedge clock) begin
        cycles = cycles + 1;
        if (num_vectors > 0 && cycles > 2 * num_vectors + 32) begin
            stop_on_error("timeout, the run did not finish within its cycle budget");
        end else if (UUT.u_props.fail_count != 0) begin
            stop_on_error("a bound assertion on the ID/EX register failed");
        end
    end

    initial begin
        int    i;
        word_t exp_pc;
        inst_t exp_inst;
        arst_n   = 1'b0;
        if_valid = 1'b0;
        if_pc    = '0;
        if_inst  = '0;
        stall    = 1'b0;
        squash   = 1'b0;
        wb       = '0;
        exp_pc   = '0;
        exp_inst = '0;
        load_vectors();
        repeat (16) @(posedge clock);
        arst_n <= 1'b1;
        apply_vector(vectors[0]);
        @(negedge clock);
        check_bit("id_ex.valid", id_ex.valid, 1'b0);   // still the reset packet
        check_ctrl(id_ex.ctrl, id_ctrl_t'('0));
        for (i = 0; i < num_vectors; i++) begin
            @(posedge clock);   // vector i lands in ID/EX here
            if (i + 1 < num_vectors) begin
                apply_vector(vectors[i + 1]);
            end else begin
                apply_vector('0);
            end
            // stall keeps the previous pc and instruction in ID/EX
            if (!vectors[i].stall) begin
                exp_pc   = vectors[i].pc;
                exp_inst = vectors[i].inst;
            end
            @(negedge clock);
            check_packet(vectors[i], exp_pc, exp_inst);
        end
        if (UUT.u_props.fail_count == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            stop_on_error("a bound assertion on the ID/EX register failed");
        end
    end

endmodule

//--- test/stage_id_testdata.txt
// valid pc inst stall squash wb_en wb_idx wb_data | expected packet one cycle later:
// valid opa opb alu_func flags(dest rd wr cbr ubr csr halt ill) rs1 rs2 imm dest_reg
1 00000000 002081b3 0 0 1 01 11111111 1 0 0 0 10000000 11111111 00000000 00000000 03 // RV32_ADD
1 00000004 40208233 0 0 1 02 22222222 1 0 0 1 10000000 11111111 22222222 00000000 04 // RV32_SUB
1 00000008 022082b3 0 0 0 00 00000000 1 0 0 a 10000000 11111111 22222222 00000000 05 // RV32_MUL
1 0000000c 02103333 0 0 1 00 deadbeef 1 0 0 d 10000000 00000000 11111111 00000000 06 // RV32_MULHU
1 00000010 fff08393 0 0 0 00 00000000 1 0 1 0 10000000 11111111 00000000 ffffffff 07 // RV32_ADDI
1 00000014 40415413 0 0 0 00 00000000 1 0 1 9 10000000 22222222 00000000 00000404 08 // RV32_SRAI
1 00000018 7ff03493 0 0 1 1f 31313131 1 0 1 3 10000000 00000000 31313131 000007ff 09 // RV32_SLTIU
1 0000001c ff812503 0 0 0 00 00000000 1 0 1 0 11000000 22222222 00000000 fffffff8 0a // RV32_LW
1 00000020 fe112e23 0 0 0 00 00000000 1 0 2 0 00100000 22222222 11111111 fffffffc 00 // RV32_SW
1 00000024 fe2098e3 0 0 0 00 00000000 1 1 3 0 00010000 11111111 22222222 fffffff0 00 // RV32_BNE
1 00000028 800005b7 0 0 0 00 00000000 1 2 4 0 10000000 00000000 00000000 80000000 0b // RV32_LUI
1 0000002c 12345617 0 0 0 00 00000000 1 1 4 0 10000000 00000000 00000000 12345000 0c // RV32_AUIPC
1 00000030 001000ef 0 0 0 00 00000000 1 1 5 0 10001000 00000000 11111111 00000800 01 // RV32_JAL
1 00000034 00008067 0 0 0 00 00000000 1 0 1 0 10001000 11111111 00000000 00000000 00 // RV32_JALR
1 00000038 300092f3 0 0 0 00 00000000 1 0 0 0 00000100 11111111 00000000 00000000 00 // RV32_CSRRW
1 0000003c 10500073 0 0 0 00 00000000 1 0 0 0 00000010 00000000 00000000 00000000 00 // RV32_WFI
1 00000040 ffffffff 0 0 0 00 00000000 1 0 0 0 00000001 31313131 31313131 00000000 00 // undefined
0 00000044 002081b3 0 0 0 00 00000000 0 0 0 0 00000000 11111111 22222222 00000000 00 // not valid
1 00000048 002081b3 0 1 0 00 00000000 0 0 0 0 00000000 00000000 00000000 00000000 00 // squash
1 0000004c 0f014693 0 0 0 00 00000000 1 0 1 6 10000000 22222222 00000000 000000f0 0d // RV32_XORI
1 00000050 0100e733 1 0 1 10 16161616 1 0 1 6 10000000 22222222 00000000 000000f0 0d // stall
1 00000050 0100e733 1 0 0 00 00000000 1 0 1 6 10000000 22222222 00000000 000000f0 0d // stall
1 00000050 0100e733 0 0 0 00 00000000 1 0 0 5 10000000 11111111 16161616 00000000 0e // RV32_OR
1 00000054 002081b3 1 1 0 00 00000000 1 0 0 5 10000000 11111111 16161616 00000000 0e // stall wins
0 00000000 00000000 0 0 0 00 00000000 0 0 0 0 00000000 00000000 00000000 00000000 00 // idle
